// File: main_golden.txt
// op(1=write) addr wdata mem okmax lvbl lhbl blank_dly sec_req nexirq
// rdata latency(0=any) snd_latch mcu_din prisel mixpsel snreq_pulses ipl_n
0 100000 0000 00 0 1 1 0 0 1 dcea 2 00 0000 0 0 0 7
0 100002 0000 00 0 1 1 0 0 1 ff65 2 00 0000 0 0 0 7
0 100004 0000 00 0 1 1 0 0 1 a73c 2 00 0000 0 0 0 7
1 100006 005a 00 0 1 1 0 0 1 0000 2 5a 0000 0 0 1 7
1 100008 beef 00 0 1 1 0 0 1 0000 2 5a beef 0 0 0 7
1 10000c 0005 00 0 1 1 0 0 1 0000 2 5a beef 5 0 0 7
1 10000e 0001 00 0 1 1 0 0 1 0000 2 5a beef 5 1 0 7
1 100006 0033 00 0 1 1 0 0 1 0000 2 33 beef 5 1 1 7
0 000100 0000 a5 6 1 1 0 0 1 10a5 0 33 beef 5 1 0 7
0 03fffe 0000 3c 3 1 1 0 0 1 103c 0 33 beef 5 1 0 7
0 040000 0000 77 8 1 1 0 0 1 1077 0 33 beef 5 1 0 7
0 140000 0000 81 5 1 1 0 0 1 2081 0 33 beef 5 1 0 7
1 140002 1234 00 4 1 1 0 0 1 0000 0 33 beef 5 1 0 7
0 080800 0000 19 2 1 0 0 0 1 2019 0 33 beef 5 1 0 7
0 081000 0000 42 0 1 1 0 0 1 5142 2 33 beef 5 1 0 7
0 0c0000 0000 0e 0 1 1 0 0 1 300e 2 33 beef 5 1 0 7
0 0e0000 0000 9d 0 1 1 6 0 1 409d 0 33 beef 5 1 0 7
0 0e0002 0000 9e 0 1 0 0 0 1 409e 2 33 beef 5 1 0 7
0 180000 0000 6b 0 1 1 0 0 1 ff6b 2 33 beef 5 1 0 7
0 1c0000 0000 00 0 1 1 0 0 1 ffff 2 33 beef 5 1 0 7
0 100004 0000 00 0 1 1 0 0 0 a73c 2 33 beef 5 1 0 3
0 100000 0000 00 0 1 1 0 1 0 dcea 2 33 beef 5 1 0 2
0 100002 0000 00 0 0 1 0 1 0 ffe5 2 33 beef 5 1 0 1
1 100010 0000 00 0 0 1 0 1 0 0000 2 33 beef 5 1 0 2
0 10000a 0000 44 0 0 1 0 1 0 6044 2 33 beef 5 1 0 3
0 1c0002 0000 00 0 1 1 0 0 1 ffff 2 33 beef 5 1 0 7

// File: tb.f
main_bus_pkg.sv
main_io_pkg.sv
main_bus_decoder.sv
main_dtack_ctrl.sv
main_read_mux.sv
main_write_latches.sv
main_irq_ctrl.sv
main_top.sv
tb_main.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_main
FILELIST   = tb.f

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: tb_main.sv
//--------------------------------------------------
// testbench for the main CPU bus glue
// replays golden bus transactions as the 68000
//--------------------------------------------------
`timescale 1ns/1ps

module tb_main;
    import main_bus_pkg::*;
    import main_io_pkg::*;

    localparam int nf        = 18;      // fields per golden line
    localparam int max_lines = 64;
    localparam int disp_wait = 2;

    logic                clk;
    logic                rst;
    logic [addr_w:1]     addr;
    logic                rnw;
    logic                uds_n;
    logic                lds_n;
    logic [data_w-1:0]   wdata;
    logic                as_n;
    logic                dtack_n;
    logic [data_w-1:0]   rdata;
    logic [7:0]          mem;           // low byte shared by all memory models
    logic                mem_ok;
    logic [data_w-1:0]   rom_data;
    logic                rom_ok;
    logic [data_w-1:0]   ram_data;
    logic                ram_ok;
    logic [data_w-1:0]   pal_data;
    logic [data_w-1:0]   obj_data;
    logic [data_w-1:0]   tile0_data;
    logic [data_w-1:0]   tile1_data;
    logic [data_w-1:0]   tile2_data;
    logic [data_w-1:0]   mcu_data;
    logic [7:0]          huc_data;
    cab_in_t             cab;
    logic                lvbl;
    logic                lhbl;
    logic                sec_req;
    logic                nexirq;
    logic [snd_w-1:0]    snd_latch;
    logic                snreq;
    logic [mcu_w-1:0]    mcu_din;
    logic [prisel_w-1:0] prisel;
    logic                mixpsel;
    logic                rom_cs;
    logic                ram_cs;
    logic [1:0]          pal_cs;
    logic                obj_cs;
    logic [2:0]          ipl_n;

    logic [31:0] gold [0:nf*max_lines-1];
    int          n_lines     = 0;
    int          errors      = 0;
    int          snreq_total = 0;

    // upper byte tags each source so a wrong mux choice shows up
    assign rom_data   = {8'h10, mem};
    assign ram_data   = {8'h20, mem};
    assign pal_data   = {8'h30, mem};
    assign obj_data   = {8'h40, mem};
    assign tile0_data = {8'h50, mem};
    assign tile1_data = {8'h51, mem};
    assign tile2_data = {8'h52, mem};
    assign mcu_data   = {8'h60, mem};
    assign huc_data   = mem;
    assign rom_ok     = mem_ok;
    assign ram_ok     = mem_ok;

    main_top #(
        .disp_wait (disp_wait)
    ) DUT (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (snreq)
            snreq_total <= snreq_total + 1;
    end

    // expected {rom, ram, pal, obj} selects for a byte address
    function automatic logic [4:0] expected_selects(input logic [23:0] a);
        logic [4:0] cs;
        cs = '0;
        case (a[20:18])
            3'd0, 3'd1: cs[4] = 1'b1;
            3'd2:       cs[3] = (a[13:12] != 2'd3) && (a[11] || a[10]);   // tile shift or map
            3'd3: begin
                cs[1] = (a[17:16] == 2'd0);     // palette bank 0
                cs[2] = (a[17:16] == 2'd1);
                cs[0] = (a[17:16] == 2'd2);     // objects
            end
            3'd5:       cs[3] = 1'b1;           // system RAM
            default: ;
        endcase
        return cs;
    endfunction

    // runs one golden line through setup, bus cycle, release and checks
    task automatic run_line(input int n);
        int          base;
        logic        is_wr;
        logic [23:0] baddr;
        int          okm;
        int          bdly;
        logic [15:0] exp_rdata;
        int          exp_lat;
        logic [7:0]  exp_snd;
        logic [15:0] exp_mcu;
        logic [2:0]  exp_pri;
        logic        exp_mix;
        int          exp_snq;
        logic [2:0]  exp_ipl;
        logic [4:0]  exp_cs;
        logic [4:0]  got_cs;
        int          dly;
        int          cycles;
        int          snq0;
        int          err0;
        base      = n * nf;
        is_wr     = gold[base][0];
        baddr     = gold[base+1][23:0];
        okm       = int'(gold[base+4]);
        bdly      = int'(gold[base+7]);
        exp_rdata = gold[base+10][15:0];
        exp_lat   = int'(gold[base+11]);
        exp_snd   = gold[base+12][7:0];
        exp_mcu   = gold[base+13][15:0];
        exp_pri   = gold[base+14][2:0];
        exp_mix   = gold[base+15][0];
        exp_snq   = int'(gold[base+16]);
        exp_ipl   = gold[base+17][2:0];
        exp_cs    = expected_selects(baddr);
        dly       = (okm == 0) ? 0 : 1 + int'($urandom % okm);
        err0      = errors;
        snq0      = snreq_total;
        @(posedge clk);
        addr    <= baddr[23:1];
        rnw     <= ~is_wr;
        uds_n   <= 1'b0;
        lds_n   <= 1'b0;
        wdata   <= gold[base+2][15:0];
        mem     <= gold[base+3][7:0];
        mem_ok  <= 1'b0;
        lvbl    <= gold[base+5][0];
        lhbl    <= gold[base+6][0];
        sec_req <= gold[base+8][0];
        nexirq  <= gold[base+9][0];
        repeat (2) @(posedge clk);      // let the irq flags settle
        as_n   <= 1'b0;
        mem_ok <= (dly == 0);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles == dly)
                mem_ok <= 1'b1;
            if (bdly != 0 && cycles == bdly)
                lhbl <= 1'b0;           // blank starts
            @(negedge clk);
        end while (dtack_n);
        if (okm != 0 && !mem_ok) begin
            $display("%0t: line %0d dtack_n fell before the memory was ready", $time, n);
            errors++;
        end
        if (bdly != 0 && lhbl) begin
            $display("%0t: line %0d dtack_n fell before blank started", $time, n);
            errors++;
        end
        if (exp_lat != 0 && cycles != exp_lat) begin
            $display("mismatch %0t: line %0d latency %0d, expected %0d",
                     $time, n, cycles, exp_lat);
            errors++;
        end
        if (!is_wr && rdata !== exp_rdata) begin
            $display("mismatch %0t: line %0d rdata %h, expected %h", $time, n, rdata, exp_rdata);
            errors++;
        end
        got_cs = {rom_cs, ram_cs, pal_cs, obj_cs};
        if (got_cs !== exp_cs) begin
            $display("mismatch %0t: line %0d chip selects %b, expected %b",
                     $time, n, got_cs, exp_cs);
            errors++;
        end
        @(posedge clk);
        as_n   <= 1'b1;
        mem_ok <= 1'b0;
        do begin
            @(negedge clk);
        end while (!dtack_n);
        repeat (2) @(negedge clk);
        got_cs = {rom_cs, ram_cs, pal_cs, obj_cs};
        if (got_cs !== 5'b0) begin
            $display("mismatch %0t: line %0d idle chip selects %b, expected 00000",
                     $time, n, got_cs);
            errors++;
        end
        if (snd_latch !== exp_snd) begin
            $display("mismatch %0t: line %0d snd_latch %h, expected %h",
                     $time, n, snd_latch, exp_snd);
            errors++;
        end
        if (mcu_din !== exp_mcu) begin
            $display("mismatch %0t: line %0d mcu_din %h, expected %h", $time, n, mcu_din, exp_mcu);
            errors++;
        end
        if (prisel !== exp_pri) begin
            $display("mismatch %0t: line %0d prisel %h, expected %h", $time, n, prisel, exp_pri);
            errors++;
        end
        if (mixpsel !== exp_mix) begin
            $display("mismatch %0t: line %0d mixpsel %b, expected %b", $time, n, mixpsel, exp_mix);
            errors++;
        end
        if (snreq_total - snq0 != exp_snq) begin
            $display("mismatch %0t: line %0d snreq pulses %0d, expected %0d",
                     $time, n, snreq_total - snq0, exp_snq);
            errors++;
        end
        if (ipl_n !== exp_ipl) begin
            $display("mismatch %0t: line %0d ipl_n %b, expected %b", $time, n, ipl_n, exp_ipl);
            errors++;
        end
        $display("test %0d %s %h: %s", n, is_wr ? "write" : "read", baddr,
                 (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        int count;
        void'($urandom(32'h47f4_43a4));
        rst     = 1'b1;
        as_n    = 1'b1;
        rnw     = 1'b1;
        uds_n   = 1'b1;
        lds_n   = 1'b1;
        addr    = '0;
        wdata   = '0;
        mem     = '0;
        mem_ok  = 1'b0;
        lvbl    = 1'b1;
        lhbl    = 1'b1;
        sec_req = 1'b0;
        nexirq  = 1'b1;
        cab.joy1    = 9'h1e5;
        cab.joy2    = 9'h0d3;
        cab.start   = 2'b01;
        cab.coin    = 2'b10;
        cab.service = 1'b1;
        cab.dipsw_a = 8'h3c;
        cab.dipsw_b = 8'ha7;
        // op field of an unused line can never read as 0 or 1
        for (int i = 0; i < nf * max_lines; i++)
            gold[i] = {16'hf0f0, i[15:0]};
        $readmemh("main_golden.txt", gold);
        count = 0;
        while (count < max_lines && gold[count*nf] < 2)
            count++;
        n_lines = count;
        if (n_lines == 0) begin
            $display("no transactions were read from main_golden.txt");
            errors++;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int n = 0; n < n_lines; n++)
            run_line(n);
        $display("tests %0d, errors %0d", n_lines, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // watchdog allows 200 cycles per golden line
    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 200) @(posedge clk);
        $display("timeout: the bus cycles did not finish within %0d cycles", n_lines * 200);
        $display("Errors found");
        $finish;
    end

endmodule

// File: main_top.sv
//--------------------------------------------------
// main CPU bus glue top level
// decode, acknowledge and data-return chain
//--------------------------------------------------
`timescale 1ns/1ps

module main_top #(
    parameter int disp_wait = 2
) (
    input  logic                               clk,
    input  logic                               rst,
    // 68000 bus
    input  logic [main_bus_pkg::addr_w:1]      addr,
    input  logic                               rnw,
    input  logic                               uds_n,
    input  logic                               lds_n,
    input  logic [main_bus_pkg::data_w-1:0]    wdata,
    input  logic                               as_n,
    output logic                               dtack_n,
    output logic [main_bus_pkg::data_w-1:0]    rdata,
    // memories and chips
    input  logic [main_bus_pkg::data_w-1:0]    rom_data,
    input  logic                               rom_ok,
    input  logic [main_bus_pkg::data_w-1:0]    ram_data,
    input  logic                               ram_ok,
    input  logic [main_bus_pkg::data_w-1:0]    pal_data,
    input  logic [main_bus_pkg::data_w-1:0]    obj_data,
    input  logic [main_bus_pkg::data_w-1:0]    tile0_data,
    input  logic [main_bus_pkg::data_w-1:0]    tile1_data,
    input  logic [main_bus_pkg::data_w-1:0]    tile2_data,
    input  logic [main_bus_pkg::data_w-1:0]    mcu_data,
    input  logic [7:0]                         huc_data,
    // cabinet and video timing
    input  main_io_pkg::cab_in_t               cab,
    input  logic                               lvbl,
    input  logic                               lhbl,
    input  logic                               sec_req,
    input  logic                               nexirq,
    // latches
    output logic [main_io_pkg::snd_w-1:0]      snd_latch,
    output logic                               snreq,
    output logic [main_io_pkg::mcu_w-1:0]      mcu_din,
    output logic [main_io_pkg::prisel_w-1:0]   prisel,
    output logic                               mixpsel,
    // chip selects
    output logic                               rom_cs,
    output logic                               ram_cs,
    output logic [1:0]                         pal_cs,
    output logic                               obj_cs,
    output logic [2:0]                         ipl_n
);
    import main_bus_pkg::*;
    import main_io_pkg::*;

    bus_req_t req;
    sel_t     sel;
    logic     ram_any;

    assign ram_any = sel.sysram | (|sel.tile_sft) | (|sel.tile_map);
    assign ram_cs  = ram_any & ~(req.uds_n & req.lds_n);   // needs a data strobe
    assign rom_cs  = sel.rom;
    assign pal_cs  = sel.pal;
    assign obj_cs  = sel.obj;

    main_bus_decoder u_decoder (
        .clk,
        .rst,
        .addr,
        .wdata,
        .rnw,
        .uds_n,
        .lds_n,
        .as_n,
        .req,
        .sel
    );

    main_dtack_ctrl #(
        .disp_wait (disp_wait)
    ) u_dtack (
        .clk,
        .rst,
        .as_n,
        .sel,
        .rom_ok,
        .ram_ok,
        .lvbl,
        .lhbl,
        .dtack_n
    );

    main_read_mux u_read_mux (
        .clk,
        .rst,
        .req,
        .sel,
        .cab,
        .lvbl,
        .rom_data,
        .ram_data,
        .pal_data,
        .obj_data,
        .tile0_data,
        .tile1_data,
        .tile2_data,
        .mcu_data,
        .huc_data,
        .rdata
    );

    main_write_latches u_latches (
        .clk,
        .rst,
        .req,
        .sel,
        .snd_latch,
        .snreq,
        .mcu_din,
        .prisel,
        .mixpsel
    );

    // reading the sub-CPU port acknowledges its interrupt
    main_irq_ctrl u_irq (
        .clk,
        .rst,
        .lvbl,
        .sec_req,
        .nexirq,
        .vint_clr (sel.vint_clr),
        .sec_clr  (sel.mcu_rd),
        .ipl_n
    );

endmodule

// File: main_irq_ctrl.sv
//--------------------------------------------------
// vblank and sub-CPU interrupt flags, and the
// interrupt priority encoder
//--------------------------------------------------
`timescale 1ns/1ps

module main_irq_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       sec_req,
    input  logic       nexirq,     // active low
    input  logic       vint_clr,
    input  logic       sec_clr,
    output logic [2:0] ipl_n
);
    import main_io_pkg::*;

    logic       lvbl_l;
    logic       sec_l;
    logic       vint;
    logic       secirq;
    irq_level_e level;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
            sec_l  <= 1'b0;
            vint   <= 1'b0;
            secirq <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            sec_l  <= sec_req;
            if (vint_clr)
                vint <= 1'b0;
            else if (!lvbl && lvbl_l)   // start of vertical blank
                vint <= 1'b1;
            if (sec_clr)
                secirq <= 1'b0;
            else if (sec_req && !sec_l)
                secirq <= 1'b1;
        end
    end

    always_comb begin
        if (vint)
            level = irq_vblank;
        else if (secirq)
            level = irq_sec;
        else if (!nexirq)
            level = irq_ext;
        else
            level = irq_none;
    end

    assign ipl_n = ~level;

endmodule

// File: main_write_latches.sv
//--------------------------------------------------
// sound, sub-CPU, priority and object-DMA latches
//--------------------------------------------------
`timescale 1ns/1ps

module main_write_latches (
    input  logic                               clk,
    input  logic                               rst,
    input  main_bus_pkg::bus_req_t             req,
    input  main_bus_pkg::sel_t                 sel,
    output logic [main_io_pkg::snd_w-1:0]      snd_latch,
    output logic                               snreq,
    output logic [main_io_pkg::mcu_w-1:0]      mcu_din,
    output logic [main_io_pkg::prisel_w-1:0]   prisel,
    output logic                               mixpsel
);
    import main_io_pkg::*;

    logic wr_any;
    logic wr_l;
    logic wr_stb;

    assign wr_any = sel.sound | sel.mcu_wr | sel.prisel | sel.mixpsel;
    assign wr_stb = wr_any & ~wr_l;     // first cycle of the write only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_l      <= 1'b0;
            snreq     <= 1'b0;
            snd_latch <= '0;
            mcu_din   <= '0;
            prisel    <= '0;
            mixpsel   <= 1'b0;
        end else begin
            wr_l  <= wr_any;
            snreq <= wr_stb & sel.sound;
            if (wr_stb) begin
                if (sel.sound)   snd_latch <= req.wdata[snd_w-1:0];
                if (sel.mcu_wr)  mcu_din   <= req.wdata[mcu_w-1:0];
                if (sel.prisel)  prisel    <= req.wdata[prisel_w-1:0];
                if (sel.mixpsel) mixpsel   <= req.wdata[0];  // obj buffer DMA mode
            end
        end
    end

endmodule

// File: main_read_mux.sv
//--------------------------------------------------
// cabinet input formatting and registered
// read-data multiplexer
//--------------------------------------------------
`timescale 1ns/1ps

module main_read_mux (
    input  logic                            clk,
    input  logic                            rst,
    input  main_bus_pkg::bus_req_t          req,
    input  main_bus_pkg::sel_t              sel,
    input  main_io_pkg::cab_in_t            cab,
    input  logic                            lvbl,
    input  logic [main_bus_pkg::data_w-1:0] rom_data,
    input  logic [main_bus_pkg::data_w-1:0] ram_data,
    input  logic [main_bus_pkg::data_w-1:0] pal_data,
    input  logic [main_bus_pkg::data_w-1:0] obj_data,
    input  logic [main_bus_pkg::data_w-1:0] tile0_data,
    input  logic [main_bus_pkg::data_w-1:0] tile1_data,
    input  logic [main_bus_pkg::data_w-1:0] tile2_data,
    input  logic [main_bus_pkg::data_w-1:0] mcu_data,
    input  logic [7:0]                      huc_data,
    output logic [main_bus_pkg::data_w-1:0] rdata
);
    import main_bus_pkg::*;
    import main_io_pkg::*;

    logic [joy_w-1:0]  sort1;
    logic [joy_w-1:0]  sort2;
    logic [data_w-1:0] cab_word;
    logic              ram_sel;

    // direction bits come in reversed order on the board
    function automatic logic [joy_w-1:0] sort_joy(input logic [joy_w-1:0] joy);
        return {joy[8:4], joy[0], joy[1], joy[2], joy[3]};
    endfunction

    assign sort1   = sort_joy(cab.joy1);
    assign sort2   = sort_joy(cab.joy2);
    assign ram_sel = sel.sysram | (|sel.tile_sft) | (|sel.tile_map);

    always_comb begin
        cab_word = '1;
        if (sel.cab_read[0])
            cab_word = {sort2[7:0], sort1[7:0]};
        else if (sel.cab_read[1])
            cab_word = {8'hff, ~lvbl, cab.service, cab.coin, cab.start, sort2[8], sort1[8]};
        else if (sel.cab_read[2])
            cab_word = {cab.dipsw_b, cab.dipsw_a};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rdata <= '1;
        else if (!req.rnw)
            rdata <= '1;                    // nothing returned on writes
        else if (ram_sel)
            rdata <= ram_data;
        else if (sel.rom)
            rdata <= rom_data;
        else if (|sel.pal)
            rdata <= pal_data;
        else if (sel.obj)
            rdata <= obj_data;
        else if (|sel.cab_read)
            rdata <= cab_word;
        else if (sel.tile_mode[0])
            rdata <= tile0_data;
        else if (sel.tile_mode[1])
            rdata <= tile1_data;
        else if (sel.tile_mode[2])
            rdata <= tile2_data;
        else if (sel.mcu_rd)
            rdata <= mcu_data;
        else if (sel.huc)
            rdata <= {8'hff, huc_data};     // 8-bit shared memory
        else
            rdata <= '1;
    end

endmodule

// File: main_dtack_ctrl.sv
//--------------------------------------------------
// data-acknowledge FSM with memory wait states
// and the display lock until blank
//--------------------------------------------------
`timescale 1ns/1ps

module main_dtack_ctrl #(
    parameter int disp_wait = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               as_n,
    input  main_bus_pkg::sel_t sel,
    input  logic               rom_ok,
    input  logic               ram_ok,
    input  logic               lvbl,
    input  logic               lhbl,
    output logic               dtack_n
);
    localparam int cnt_w = $clog2(disp_wait + 2);

    typedef enum logic [1:0] {st_idle, st_wait, st_ack} state_e;

    state_e           state;
    logic             as_l;
    logic             rom_ok_l;
    logic             blank_l;
    logic             lock;     // display access outside blank
    logic             cnt_run;
    logic [cnt_w-1:0] cnt;
    logic             blank;
    logic             ram_sel;
    logic             busy;

    assign blank   = ~lvbl | ~lhbl;
    assign ram_sel = sel.sysram | (|sel.tile_sft) | (|sel.tile_map);
    assign busy    = (sel.rom & ~rom_ok_l) | (ram_sel & ~ram_ok) | lock;
    assign dtack_n = state != st_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            as_l     <= 1'b1;
            rom_ok_l <= 1'b0;
            blank_l  <= 1'b0;
            lock     <= 1'b0;
            cnt_run  <= 1'b0;
            cnt      <= '0;
        end else begin
            as_l     <= as_n;
            rom_ok_l <= rom_ok;
            blank_l  <= blank;
            case (state)
                st_idle: begin
                    if (!as_n && !as_l) begin   // selects valid now
                        lock  <= sel.disp & ~blank;
                        state <= (sel.rom | ram_sel | (sel.disp & ~blank)) ? st_wait : st_ack;
                    end
                end
                st_wait: begin
                    if (as_n)
                        state <= st_idle;
                    else if (!busy)
                        state <= st_ack;
                end
                st_ack:  if (as_n) state <= st_idle;
                default: state <= st_idle;
            endcase
            // lock release, blank edge then a short count
            if (as_n) begin
                lock    <= 1'b0;
                cnt_run <= 1'b0;
            end else if (lock) begin
                if (blank && !blank_l) begin
                    cnt     <= cnt_w'(disp_wait);
                    cnt_run <= 1'b1;
                end else if (cnt_run) begin
                    if (cnt == '0) begin
                        lock    <= 1'b0;
                        cnt_run <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: main_bus_decoder.sv
//--------------------------------------------------
// bus cycle capture and chip-select decoder
//--------------------------------------------------
`timescale 1ns/1ps

module main_bus_decoder (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [main_bus_pkg::addr_w:1]    addr,
    input  logic [main_bus_pkg::data_w-1:0]  wdata,
    input  logic                             rnw,
    input  logic                             uds_n,
    input  logic                             lds_n,
    input  logic                             as_n,
    output main_bus_pkg::bus_req_t           req,
    output main_bus_pkg::sel_t               sel
);
    import main_bus_pkg::*;
    import main_io_pkg::*;

    logic       active;         // cycle already captured
    logic [1:0] chip;
    region_e    region;
    sel_t       dec;

    assign region = region_e'(addr[20:18]);
    assign chip   = addr[13:12];

    always_comb begin
        dec = '0;
        case (region)
            rgn_rom0, rgn_rom1: dec.rom = 1'b1;
            rgn_tile: begin
                if (chip != 2'd3) begin
                    if (addr[11])
                        dec.tile_map[chip] = 1'b1;
                    else if (addr[10])
                        dec.tile_sft[chip] = 1'b1;
                    else
                        dec.tile_mode[chip] = 1'b1;
                end
            end
            rgn_video: begin
                case (addr[17:16])
                    2'd0: dec.pal[0]   = 1'b1;
                    2'd1: dec.pal[1]   = 1'b1;
                    2'd2: dec.obj      = 1'b1;
                    default: dec.obj_copy = 1'b1;
                endcase
            end
            rgn_io: begin
                case (io_reg_e'(addr[4:1]))
                    io_cab0:     dec.cab_read[0] = rnw;
                    io_cab1:     dec.cab_read[1] = rnw;
                    io_cab2:     dec.cab_read[2] = rnw;
                    io_sound:    dec.sound       = ~rnw;
                    io_mcu_wr:   dec.mcu_wr      = ~rnw;
                    io_mcu_rd:   dec.mcu_rd      = rnw;
                    io_prisel:   dec.prisel      = ~rnw;
                    io_mixpsel:  dec.mixpsel     = ~rnw;
                    io_vint_clr: dec.vint_clr    = ~rnw;
                    default: ;
                endcase
            end
            rgn_sysram: dec.sysram = 1'b1;
            rgn_huc:    dec.huc    = 1'b1;
            default: ;
        endcase
        dec.disp = (|dec.tile_sft) | (|dec.tile_map) | dec.obj;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            req    <= '0;
            sel    <= '0;
        end else if (as_n) begin
            active <= 1'b0;
            sel    <= '0;       // selects only live inside a cycle
        end else if (!active) begin
            active <= 1'b1;
            sel    <= dec;
            req    <= '{addr: addr, rnw: rnw, uds_n: uds_n, lds_n: lds_n,
                        wdata: wdata, region: region};
        end
    end

endmodule

// File: main_io_pkg.sv
//--------------------------------------------------
// cabinet inputs, interrupt levels, io word map
// and latch widths
//--------------------------------------------------
package main_io_pkg;

    localparam int joy_w    = 9;
    localparam int dip_w    = 8;
    localparam int snd_w    = 8;
    localparam int mcu_w    = 16;
    localparam int prisel_w = 3;

    // joysticks are active low, bits 3:0 directions, bit 8 fire 2
    typedef struct packed {
        logic [joy_w-1:0] joy1;
        logic [joy_w-1:0] joy2;
        logic [1:0]       start;
        logic [1:0]       coin;
        logic             service;
        logic [dip_w-1:0] dipsw_a;
        logic [dip_w-1:0] dipsw_b;
    } cab_in_t;

    typedef enum logic [2:0] {
        irq_none   = 3'd0,
        irq_ext    = 3'd4,
        irq_sec    = 3'd5,
        irq_vblank = 3'd6
    } irq_level_e;

    // io word offsets on address bits 4:1
    typedef enum logic [3:0] {
        io_cab0     = 4'd0,
        io_cab1     = 4'd1,
        io_cab2     = 4'd2,
        io_sound    = 4'd3,
        io_mcu_wr   = 4'd4,
        io_mcu_rd   = 4'd5,
        io_prisel   = 4'd6,
        io_mixpsel  = 4'd7,
        io_vint_clr = 4'd8
    } io_reg_e;

endpackage

// File: main_bus_pkg.sv
//--------------------------------------------------
// main CPU bus widths, address regions and the
// registered bus request and chip-select structs
//--------------------------------------------------
package main_bus_pkg;

    localparam int addr_w = 23;     // bus bits 23:1
    localparam int data_w = 16;

    // address bits 20:18
    typedef enum logic [2:0] {
        rgn_rom0   = 3'd0,
        rgn_rom1   = 3'd1,
        rgn_tile   = 3'd2,          // background tile chips
        rgn_video  = 3'd3,          // palette and objects
        rgn_io     = 3'd4,
        rgn_sysram = 3'd5,
        rgn_huc    = 3'd6,          // protection shared memory
        rgn_none   = 3'd7
    } region_e;

    typedef struct packed {
        logic [addr_w:1]   addr;
        logic              rnw;
        logic              uds_n;
        logic              lds_n;
        logic [data_w-1:0] wdata;
        region_e           region;
    } bus_req_t;

    typedef struct packed {
        logic       rom;
        logic       sysram;
        logic [2:0] tile_mode;      // one bit per tile chip
        logic [2:0] tile_sft;
        logic [2:0] tile_map;
        logic [1:0] pal;
        logic       obj;
        logic       obj_copy;       // object DMA trigger
        logic       huc;
        logic [2:0] cab_read;
        logic       sound;
        logic       mcu_wr;
        logic       mcu_rd;
        logic       prisel;
        logic       mixpsel;
        logic       vint_clr;
        logic       disp;           // tile shift/map or obj
    } sel_t;

endpackage
